/* ucstats_pkg.sv */
/*
 * uC statistics block shared definitions
 * widths, address fields, constants, state encodings and stage structs
 */
package ucstats_pkg;

   // ----------------------------------------
   // widths
   // ----------------------------------------
   localparam int byte_w     = 8;
   localparam int word_w     = 32;
   // 5b sfp selector above 5b word offset
   localparam int ram_addr_w = 10;
   localparam int ram_depth  = 1 << ram_addr_w;
   localparam int uc_addr_w  = 16;

   // ----------------------------------------
   // uC address fields
   // ----------------------------------------
   // set on a write, clear on a read
   localparam int addr_wr_bit = 15;
   // bits 14..11 must be zero
   localparam int rsvd_lsb    = 11;
   localparam int rsvd_w      = 4;
   // address space select in bits 11..10
   localparam int space_lsb   = 10;

   localparam logic [1:0] space_stat = 2'd0;
   localparam logic [1:0] space_fpga = 2'd1;

   // fpga space offsets
   localparam logic [ram_addr_w-1:0] ofs_interval_mark = 10'd1;
   localparam logic [ram_addr_w-1:0] ofs_id            = 10'd2;

   localparam logic [word_w-1:0] id_word       = 32'hc001_c0de;
   localparam logic [word_w-1:0] bad_addr_word = 32'hdead_beef;

   // equal samples needed before a control level is taken
   localparam int debounce_len = 2;
   localparam int deb_cnt_w    = $clog2(debounce_len + 1);

   // ----------------------------------------
   // state encodings
   // ----------------------------------------
   typedef enum logic [4:0] {
      uc_idle       = 5'h00, uc_addr0      = 5'h01, uc_addr1      = 5'h02,
      uc_addr_dec   = 5'h03, uc_data0      = 5'h04, uc_data0_b    = 5'h05,
      uc_data1      = 5'h06, uc_data2      = 5'h07, uc_data3      = 5'h08,
      uc_wr_ram     = 5'h09, uc_rd_ram     = 5'h0a, uc_rd_master  = 5'h0b,
      uc_rd_master2 = 5'h0c, uc_rd_drive0  = 5'h0d, uc_rd_drive1  = 5'h0e,
      uc_rd_drive2  = 5'h0f, uc_rd_drive3  = 5'h10, uc_rd_done    = 5'h11,
      uc_invalid_wr = 5'h12, uc_early_done = 5'h13, uc_done       = 5'h14,
      uc_error      = 5'h1f
   } uc_state_e;

   typedef enum logic [2:0] {
      bank_idle          = 3'h0,
      bank_writing       = 3'h1,
      bank_interval_done = 3'h2,
      bank_update        = 3'h3,
      bank_error         = 3'h7
   } bank_state_e;

   // ----------------------------------------
   // stage structs
   // ----------------------------------------
   typedef struct packed {
      logic              cs;
      logic              master;
      logic              valid_rise;
      logic              valid_fall;
      logic [byte_w-1:0] data;
   } uc_bus_t;

   typedef struct packed {
      logic                  wr_en;
      logic                  rd_en;
      logic [ram_addr_w-1:0] addr;
      logic [word_w-1:0]     data;
   } stat_access_t;

endpackage

/* uc_input_sync.sv */
/*
 * uC pin input stage
 * dual-flop sync, debounce of cs/valid/master, valid edge pulses
 */
module uc_input_sync (
   input  logic                           clk,
   input  logic                           uc_rst_n,
   input  logic                           cs,
   input  logic                           valid,
   input  logic                           master,
   input  logic [ucstats_pkg::byte_w-1:0] data,
   output ucstats_pkg::uc_bus_t           bus
);

   // sync vector holds cs, valid, master then the data byte
   logic [ucstats_pkg::byte_w+2:0]          meta_q;
   logic [ucstats_pkg::byte_w+2:0]          sync_q;
   logic [2:0]                              ctl_s;
   // debounced controls, same order: cs valid master
   logic [2:0]                              deb_q;
   logic [2:0][ucstats_pkg::deb_cnt_w-1:0]  cnt_q;
   logic                                    valid_q;

   // ----------------------------------------
   // synchronizers
   // ----------------------------------------
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= {cs, valid, master, data};
         sync_q <= meta_q;
      end
   end

   assign ctl_s = sync_q[ucstats_pkg::byte_w +: 3];

   // ----------------------------------------
   // debounce and edge detect
   // ----------------------------------------
   // a level is taken after debounce_len samples in a row that differ from it,
   // one odd sample restarts the count
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         cnt_q   <= '0;
         deb_q   <= '0;
         valid_q <= 1'b0;
      end else begin
         for (int i = 0; i < 3; i++) begin
            if (ctl_s[i] == deb_q[i]) begin
               cnt_q[i] <= '0;
            end else if (cnt_q[i] == ucstats_pkg::deb_cnt_w'(ucstats_pkg::debounce_len - 1)) begin
               deb_q[i] <= ctl_s[i];
               cnt_q[i] <= '0;
            end else begin
               cnt_q[i] <= cnt_q[i] + 1'b1;
            end
         end
         // previous debounced valid for the edge pulses
         valid_q <= deb_q[1];
      end
   end

   assign bus.cs         = deb_q[2];
   assign bus.master     = deb_q[0];
   assign bus.valid_rise = deb_q[1] & ~valid_q;
   assign bus.valid_fall = ~deb_q[1] & valid_q;
   // data only sees the sync delay, it settles well before valid is accepted
   assign bus.data       = sync_q[ucstats_pkg::byte_w-1:0];

endmodule

/* uc_transfer_fsm.sv */
/*
 * uC register transfer sequencer
 * collects address and write words, decodes, drives read bytes back
 */
module uc_transfer_fsm (
   input  logic                           clk,
   input  logic                           uc_rst_n,
   input  ucstats_pkg::uc_bus_t           bus,
   input  logic [ucstats_pkg::word_w-1:0] uc_rd_data,
   output ucstats_pkg::stat_access_t      access,
   output logic                           wr_commit,
   output logic                           interval_mark,
   output logic [ucstats_pkg::byte_w-1:0] data_out,
   output logic                           data_out_val
);

   ucstats_pkg::uc_state_e                state_q;
   ucstats_pkg::uc_state_e                state_d;
   logic [ucstats_pkg::uc_addr_w-1:0]     addr_q;
   logic [ucstats_pkg::word_w-1:0]        data_q;
   logic [ucstats_pkg::word_w-1:0]        rd_word_q;
   logic                                  rd_cap_q;
   logic                                  is_wr;
   logic                                  rsvd_set;
   logic [1:0]                            space;
   logic [ucstats_pkg::ram_addr_w-1:0]    ofs;
   logic                                  in_fpga;
   logic                                  is_id;
   logic                                  addr_bad;

   // ----------------------------------------
   // address decode
   // ----------------------------------------
   assign is_wr    = addr_q[ucstats_pkg::addr_wr_bit];
   assign rsvd_set = |addr_q[ucstats_pkg::rsvd_lsb +: ucstats_pkg::rsvd_w];
   assign space    = addr_q[ucstats_pkg::space_lsb +: 2];
   assign ofs      = addr_q[ucstats_pkg::ram_addr_w-1:0];
   assign in_fpga  = (space == ucstats_pkg::space_fpga);
   assign is_id    = in_fpga & (ofs == ucstats_pkg::ofs_id);

   // fpga space only has the id word for reads and the interval mark for writes
   assign addr_bad = rsvd_set |
                     (in_fpga & ~is_wr & (ofs != ucstats_pkg::ofs_id)) |
                     (in_fpga &  is_wr & (ofs != ucstats_pkg::ofs_interval_mark));

   assign interval_mark = is_wr & ~rsvd_set & in_fpga & (ofs == ucstats_pkg::ofs_interval_mark);

   // ----------------------------------------
   // transfer sequencer
   // ----------------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         ucstats_pkg::uc_idle:
            if (bus.cs) state_d = ucstats_pkg::uc_addr0;
         // address bytes, low first
         ucstats_pkg::uc_addr0:
            if (!bus.cs) state_d = ucstats_pkg::uc_early_done;
            else if (bus.valid_rise) state_d = ucstats_pkg::uc_addr1;
         ucstats_pkg::uc_addr1:
            if (!bus.cs) state_d = ucstats_pkg::uc_early_done;
            else if (bus.valid_rise) state_d = ucstats_pkg::uc_addr_dec;
         // bad read skips the RAM, bad write waits out cs
         ucstats_pkg::uc_addr_dec:
            if (!bus.cs) state_d = ucstats_pkg::uc_early_done;
            else if (addr_bad) state_d = is_wr ? ucstats_pkg::uc_invalid_wr
                                               : ucstats_pkg::uc_rd_master;
            else state_d = is_wr ? ucstats_pkg::uc_data0 : ucstats_pkg::uc_rd_ram;
         ucstats_pkg::uc_data0:
            if (!bus.cs) state_d = ucstats_pkg::uc_early_done;
            else if (bus.valid_rise) state_d = ucstats_pkg::uc_data1;
         // after a full word a cs drop is a normal end
         ucstats_pkg::uc_data0_b:
            if (!bus.cs) state_d = ucstats_pkg::uc_done;
            else if (bus.valid_rise) state_d = ucstats_pkg::uc_data1;
         ucstats_pkg::uc_data1:
            if (!bus.cs) state_d = ucstats_pkg::uc_early_done;
            else if (bus.valid_rise) state_d = ucstats_pkg::uc_data2;
         ucstats_pkg::uc_data2:
            if (!bus.cs) state_d = ucstats_pkg::uc_early_done;
            else if (bus.valid_rise) state_d = ucstats_pkg::uc_data3;
         // interval mark words are not written to RAM
         ucstats_pkg::uc_data3:
            if (!bus.cs) state_d = ucstats_pkg::uc_early_done;
            else if (bus.valid_rise) state_d = interval_mark ? ucstats_pkg::uc_data0_b
                                                             : ucstats_pkg::uc_wr_ram;
         ucstats_pkg::uc_wr_ram:
            state_d = ucstats_pkg::uc_data0_b;
         ucstats_pkg::uc_rd_ram:
            state_d = bus.cs ? ucstats_pkg::uc_rd_master : ucstats_pkg::uc_early_done;
         // second address byte must fall before master is looked at
         ucstats_pkg::uc_rd_master:
            if (!bus.cs) state_d = ucstats_pkg::uc_early_done;
            else if (bus.valid_fall) state_d = ucstats_pkg::uc_rd_master2;
         ucstats_pkg::uc_rd_master2:
            if (!bus.cs) state_d = ucstats_pkg::uc_early_done;
            else if (!bus.master) state_d = ucstats_pkg::uc_rd_drive0;
         ucstats_pkg::uc_rd_drive0:
            if (!bus.cs) state_d = ucstats_pkg::uc_early_done;
            else if (bus.valid_fall) state_d = ucstats_pkg::uc_rd_drive1;
         ucstats_pkg::uc_rd_drive1:
            if (!bus.cs) state_d = ucstats_pkg::uc_early_done;
            else if (bus.valid_fall) state_d = ucstats_pkg::uc_rd_drive2;
         ucstats_pkg::uc_rd_drive2:
            if (!bus.cs) state_d = ucstats_pkg::uc_early_done;
            else if (bus.valid_fall) state_d = ucstats_pkg::uc_rd_drive3;
         ucstats_pkg::uc_rd_drive3:
            if (!bus.cs) state_d = ucstats_pkg::uc_early_done;
            else if (bus.valid_fall) state_d = ucstats_pkg::uc_rd_done;
         ucstats_pkg::uc_rd_done,
         ucstats_pkg::uc_invalid_wr:
            if (!bus.cs) state_d = ucstats_pkg::uc_done;
         ucstats_pkg::uc_early_done,
         ucstats_pkg::uc_done:
            state_d = ucstats_pkg::uc_idle;
         default:
            state_d = ucstats_pkg::uc_error;
      endcase
   end

   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         state_q  <= ucstats_pkg::uc_idle;
         addr_q   <= '0;
         rd_cap_q <= 1'b0;
      end else begin
         state_q  <= state_d;
         rd_cap_q <= (state_q == ucstats_pkg::uc_rd_ram);
         if (state_q == ucstats_pkg::uc_addr0 && bus.valid_rise) begin
            addr_q[7:0] <= bus.data;
         end else if (state_q == ucstats_pkg::uc_addr1 && bus.valid_rise) begin
            addr_q[15:8] <= bus.data;
         end else if (state_q == ucstats_pkg::uc_wr_ram) begin
            // auto-increment for the next word of a burst
            addr_q <= addr_q + 1'b1;
         end
      end
   end

   // ----------------------------------------
   // word assembly and read word
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (bus.valid_rise) begin
         case (state_q)
            ucstats_pkg::uc_data0,
            ucstats_pkg::uc_data0_b: data_q[7:0]   <= bus.data;
            ucstats_pkg::uc_data1:   data_q[15:8]  <= bus.data;
            ucstats_pkg::uc_data2:   data_q[23:16] <= bus.data;
            ucstats_pkg::uc_data3:   data_q[31:24] <= bus.data;
            default: ;
         endcase
      end
      if (state_q == ucstats_pkg::uc_addr_dec && addr_bad) begin
         rd_word_q <= ucstats_pkg::bad_addr_word;
      end else if (rd_cap_q) begin
         rd_word_q <= is_id ? ucstats_pkg::id_word : uc_rd_data;
      end
   end

   assign wr_commit     = (state_q == ucstats_pkg::uc_wr_ram);
   assign access.wr_en  = wr_commit;
   // id word is a constant, RAM is only read for stat space
   assign access.rd_en  = (state_q == ucstats_pkg::uc_rd_ram) & (space == ucstats_pkg::space_stat);
   assign access.addr   = ofs;
   assign access.data   = data_q;

   // read bytes go out low first, one per valid fall
   always_comb begin
      data_out_val = 1'b1;
      case (state_q)
         ucstats_pkg::uc_rd_drive0: data_out = rd_word_q[7:0];
         ucstats_pkg::uc_rd_drive1: data_out = rd_word_q[15:8];
         ucstats_pkg::uc_rd_drive2: data_out = rd_word_q[23:16];
         ucstats_pkg::uc_rd_drive3: data_out = rd_word_q[31:24];
         default: begin
            data_out     = '0;
            data_out_val = 1'b0;
         end
      endcase
   end

endmodule

/* stat_bank_ctrl.sv */
/*
 * statistics bank controller
 * swaps the uC bank after an interval mark once no LE read is open
 */
module stat_bank_ctrl (
   input  logic clk,
   input  logic uc_rst_n,
   input  logic wr_commit,
   input  logic interval_mark,
   input  logic le_req,
   input  logic le_done,
   output logic wrbank_sel,
   output logic gnt
);

   ucstats_pkg::bank_state_e state_q;
   logic                     le_active_q;
   logic                     le_active;

   // LE read is open from the request level until the done pulse
   assign le_active = le_active_q | le_req;

   // ----------------------------------------
   // bank swap state machine
   // ----------------------------------------
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         state_q <= ucstats_pkg::bank_idle;
      end else begin
         case (state_q)
            ucstats_pkg::bank_idle:
               if (wr_commit) state_q <= ucstats_pkg::bank_writing;
            ucstats_pkg::bank_writing:
               if (interval_mark) state_q <= ucstats_pkg::bank_interval_done;
            // a fresh commit cancels this swap, an open LE read defers it
            ucstats_pkg::bank_interval_done:
               if (wr_commit) state_q <= ucstats_pkg::bank_writing;
               else if (!le_active) state_q <= ucstats_pkg::bank_update;
            ucstats_pkg::bank_update:
               state_q <= ucstats_pkg::bank_idle;
            default:
               state_q <= ucstats_pkg::bank_error;
         endcase
      end
   end

   // ----------------------------------------
   // bank select, LE tracking, grant
   // ----------------------------------------
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         wrbank_sel  <= 1'b0;
         le_active_q <= 1'b0;
         gnt         <= 1'b0;
      end else begin
         if (state_q == ucstats_pkg::bank_update) wrbank_sel <= ~wrbank_sel;
         if (le_req) le_active_q <= 1'b1;
         else if (le_done) le_active_q <= 1'b0;
         // only the first cycle of a held request is granted
         gnt <= le_req & ~le_active_q;
      end
   end

endmodule

/* stat_ram_dual.sv */
/*
 * double-banked statistics RAM
 * uC owns the bank named by wrbank_sel, LE reads the other one
 */
module stat_ram_dual (
   input  logic                               clk,
   input  logic                               uc_rst_n,
   input  ucstats_pkg::stat_access_t          access,
   input  logic                               wrbank_sel,
   input  logic [ucstats_pkg::ram_addr_w-1:0] le_addr,
   output logic [ucstats_pkg::word_w-1:0]     uc_rd_data,
   output logic [ucstats_pkg::word_w-1:0]     le_data
);

   // registered read word of each bank
   logic [ucstats_pkg::word_w-1:0] rd_q [2];

   // ----------------------------------------
   // banks
   // ----------------------------------------
   for (genvar b = 0; b < 2; b++) begin : g_bank
      logic [ucstats_pkg::word_w-1:0]     mem [ucstats_pkg::ram_depth];
      logic                               uc_owns;
      logic [ucstats_pkg::ram_addr_w-1:0] rd_addr;

      assign uc_owns = (wrbank_sel == 1'(b));
      // read port is steered to whoever owns the bank
      assign rd_addr = uc_owns ? access.addr : le_addr;

      always_ff @(posedge clk) begin
         if (uc_owns && access.wr_en) begin
            mem[access.addr] <= access.data;
         end
         // uC side only updates on its read request, LE side every cycle
         if (!uc_owns || access.rd_en) begin
            rd_q[b] <= mem[rd_addr];
         end
      end
   end

   assign uc_rd_data = rd_q[wrbank_sel];

   // extra stage for the 2 cycle LE latency
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         le_data <= '0;
      end else begin
         le_data <= rd_q[~wrbank_sel];
      end
   end

endmodule

/* ucstats_top.sv */
/*
 * uC statistics block top level
 * input sync, transfer FSM, bank controller and dual-bank RAM
 */
module ucstats_top (
   input  logic                               clk,
   input  logic                               uc_rst_n,
   // uC register transfer bus
   input  logic                               uc_cs,
   input  logic                               uc_valid,
   input  logic                               uc_master,
   input  logic [ucstats_pkg::byte_w-1:0]     uc_data_in,
   output logic [ucstats_pkg::byte_w-1:0]     uc_data_out,
   output logic                               uc_data_out_val,
   // link engine read port
   input  logic                               le_req,
   input  logic [ucstats_pkg::ram_addr_w-1:0] le_addr,
   input  logic                               le_done,
   output logic [ucstats_pkg::word_w-1:0]     le_data,
   output logic                               le_gnt
);

   ucstats_pkg::uc_bus_t           bus;
   ucstats_pkg::stat_access_t      access;
   logic                           wr_commit;
   logic                           interval_mark;
   logic                           wrbank_sel;
   logic [ucstats_pkg::word_w-1:0] uc_rd_data;

   uc_input_sync u_sync (
      .clk      (clk),
      .uc_rst_n (uc_rst_n),
      .cs       (uc_cs),
      .valid    (uc_valid),
      .master   (uc_master),
      .data     (uc_data_in),
      .bus      (bus)
   );

   uc_transfer_fsm u_xfer (
      .clk           (clk),
      .uc_rst_n      (uc_rst_n),
      .bus           (bus),
      .uc_rd_data    (uc_rd_data),
      .access        (access),
      .wr_commit     (wr_commit),
      .interval_mark (interval_mark),
      .data_out      (uc_data_out),
      .data_out_val  (uc_data_out_val)
   );

   stat_bank_ctrl u_bank (
      .clk           (clk),
      .uc_rst_n      (uc_rst_n),
      .wr_commit     (wr_commit),
      .interval_mark (interval_mark),
      .le_req        (le_req),
      .le_done       (le_done),
      .wrbank_sel    (wrbank_sel),
      .gnt           (le_gnt)
   );

   stat_ram_dual u_ram (
      .clk        (clk),
      .uc_rst_n   (uc_rst_n),
      .access     (access),
      .wrbank_sel (wrbank_sel),
      .le_addr    (le_addr),
      .uc_rd_data (uc_rd_data),
      .le_data    (le_data)
   );

endmodule

/* ucstats_properties.sv */
/*
 * bank controller checks
 * grant, done and bank select held against the open LE read
 */
module ucstats_properties (
   input logic                     clk,
   input logic                     uc_rst_n,
   input logic                     gnt,
   input logic                     le_done,
   input logic                     le_active_q,
   input logic                     wrbank_sel,
   input ucstats_pkg::bank_state_e state_q
);
   timeunit 1ns;
   timeprecision 100ps;

   // grant lands in the cycle the read opens
   gnt_in_read: assert property (@(posedge clk) disable iff (!uc_rst_n)
      gnt |-> le_active_q)
      else $error("LE grant without an open read");

   done_in_read: assert property (@(posedge clk) disable iff (!uc_rst_n)
      le_done |-> le_active_q)
      else $error("LE done without an open read");

   // no swap under an open read
   bank_held: assert property (@(posedge clk) disable iff (!uc_rst_n)
      le_active_q |=> $stable(wrbank_sel))
      else $error("bank select changed during an LE read");

   no_error_state: assert property (@(posedge clk) disable iff (!uc_rst_n)
      state_q != ucstats_pkg::bank_error)
      else $error("bank state machine reached its error state");

endmodule

bind stat_bank_ctrl ucstats_properties props_i (
   .clk         (clk),
   .uc_rst_n    (uc_rst_n),
   .gnt         (gnt),
   .le_done     (le_done),
   .le_active_q (le_active_q),
   .wrbank_sel  (wrbank_sel),
   .state_q     (state_q)
);

/* ucstats_top_tb.sv */
/*
 * testbench for the uC statistics block
 * drives the uC byte bus and the LE read port, checks words against a bank model
 */
module ucstats_top_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int clk_period  = 8;
   localparam int hold_cycles = 8;
   // worst uC transaction: cs edges, master turn, 2 address and 16 data bytes
   localparam int xfer_cycles = hold_cycles * 40;
   localparam int n_xfers     = 24;

   logic        clk = 1'b0;
   logic        uc_rst_n;
   logic        uc_cs;
   logic        uc_valid;
   logic        uc_master;
   logic [7:0]  uc_data_in;
   logic [7:0]  uc_data_out;
   logic        uc_data_out_val;
   logic        le_req;
   logic [9:0]  le_addr;
   logic        le_done;
   logic [31:0] le_data;
   logic        le_gnt;

   // reference model of both banks
   logic [31:0] bank_m [2][1024];
   logic        sel_m;
   logic        dirty_m;
   logic        pending_m;
   logic        le_open_m;

   // returned words waiting for the compare process
   logic [31:0] got_q [$];
   logic [31:0] exp_q [$];
   string       what_q [$];
   logic [31:0] got_w;
   logic [31:0] exp_w;
   string       what_s;
   int          checks;
   int          errors;
   int          test_checks;
   int          test_errors;
   int          seed = 21528;

   ucstats_top dut_i (
      .clk             (clk),
      .uc_rst_n        (uc_rst_n),
      .uc_cs           (uc_cs),
      .uc_valid        (uc_valid),
      .uc_master       (uc_master),
      .uc_data_in      (uc_data_in),
      .uc_data_out     (uc_data_out),
      .uc_data_out_val (uc_data_out_val),
      .le_req          (le_req),
      .le_addr         (le_addr),
      .le_done         (le_done),
      .le_data         (le_data),
      .le_gnt          (le_gnt)
   );

   always #(clk_period / 2) clk = ~clk;

   // ----------------------------------------
   // reference model
   // ----------------------------------------
   function automatic bit addr_ok(input logic [15:0] a);
      // reserved bits, then fpga space: id read and mark write only
      if (a[14:12] != 3'd0 || a[11]) return 1'b0;
      if (a[10] && !a[15] && a[9:0] != 10'd2) return 1'b0;
      if (a[10] && a[15] && a[9:0] != 10'd1) return 1'b0;
      return 1'b1;
   endfunction

   function automatic void swap_banks();
      sel_m     = !sel_m;
      dirty_m   = 1'b0;
      pending_m = 1'b0;
   endfunction

   function automatic void note_write(input logic [15:0] a, input logic [31:0] w);
      if (!addr_ok(a)) return;
      if (a[10]) begin
         // mark only swaps after some word was written, an open LE read defers it
         if (dirty_m && le_open_m) pending_m = 1'b1;
         else if (dirty_m) swap_banks();
      end else begin
         bank_m[sel_m][a[9:0]] = w;
         dirty_m   = 1'b1;
         pending_m = 1'b0;
      end
   endfunction

   function automatic logic [31:0] expect_read(input bit from_le, input logic [15:0] a);
      if (from_le) return bank_m[!sel_m][a[9:0]];
      if (!addr_ok(a)) return 32'hdead_beef;
      if (a[10]) return 32'hc001_c0de;
      return bank_m[sel_m][a[9:0]];
   endfunction

   // ----------------------------------------
   // reporting and compare process
   // ----------------------------------------
   function automatic void report_mismatch(input string msg);
      $display("[ERROR] %0d ns: %s", $time, msg);
      errors++;
      test_errors++;
   endfunction

   function automatic void report_failure(input string msg);
      $display("%s", msg);
      errors++;
      test_errors++;
   endfunction

   function automatic void push_result(input logic [31:0] got, input logic [31:0] exp,
                                       input string what);
      got_q.push_back(got);
      exp_q.push_back(exp);
      what_q.push_back(what);
   endfunction

   always @(negedge clk) begin
      while (got_q.size() != 0) begin
         got_w  = got_q.pop_front();
         exp_w  = exp_q.pop_front();
         what_s = what_q.pop_front();
         checks++;
         test_checks++;
         assert (got_w === exp_w)
            else report_mismatch($sformatf("%s gave %h, expected %h", what_s, got_w, exp_w));
      end
   end

   // the block may drive only while the uC has let go of the bus
   always @(negedge clk) begin
      if (uc_rst_n) begin
         assert (!(uc_data_out_val && uc_master))
            else report_mismatch("data_out_val high while master is high");
      end
   end

   task automatic report_test(input string name);
      while (got_q.size() != 0) @(negedge clk);
      $display("%-30s %0d checks, %0d errors", name, test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
   endtask

   // ----------------------------------------
   // uC bus tasks, all start on a rising edge
   // ----------------------------------------
   task automatic hold_pins(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic send_byte(input logic [7:0] b);
      uc_data_in <= b;
      uc_valid   <= 1'b1;
      hold_pins(hold_cycles);
      uc_valid   <= 1'b0;
      hold_pins(hold_cycles);
   endtask

   task automatic start_xfer(input logic [15:0] a);
      @(posedge clk);
      uc_cs <= 1'b1;
      hold_pins(hold_cycles);
      send_byte(a[7:0]);
      send_byte(a[15:8]);
   endtask

   task automatic end_xfer();
      uc_cs <= 1'b0;
      hold_pins(hold_cycles);
   endtask

   task automatic uc_write_burst(input logic [15:0] a, input int n);
      logic [15:0] cur;
      logic [31:0] w;
      int          i;
      int          k;
      cur = a;
      start_xfer(a);
      for (i = 0; i < n; i++) begin
         w = $random(seed);
         for (k = 0; k < 4; k++) send_byte(w[8*k +: 8]);
         note_write(cur, w);
         // address steps only after a committed stat word
         if (addr_ok(cur) && !cur[10]) cur = cur + 16'd1;
      end
      end_xfer();
   endtask

   task automatic uc_abort(input logic [15:0] a, input int nbytes);
      logic [31:0] w;
      int          k;
      start_xfer(a);
      for (k = 0; k < nbytes; k++) begin
         w = $random(seed);
         send_byte(w[7:0]);
      end
      end_xfer();
   endtask

   task automatic uc_read(input logic [15:0] a);
      logic [31:0] got;
      int          waited;
      int          k;
      got    = '0;
      waited = 0;
      start_xfer(a);
      // hand the bus over, then wait for byte 0
      uc_master <= 1'b0;
      do begin
         @(negedge clk);
         waited++;
      end while (!uc_data_out_val && waited < 32);
      if (!uc_data_out_val) report_failure("no read data driven after the uC released the bus");
      for (k = 0; k < 4; k++) begin
         @(posedge clk);
         uc_valid <= 1'b1;
         hold_pins(hold_cycles);
         @(negedge clk);
         assert (uc_data_out_val)
            else report_mismatch($sformatf("data_out_val low during read byte %0d", k));
         got[8*k +: 8] = uc_data_out;
         @(posedge clk);
         uc_valid <= 1'b0;
         hold_pins(hold_cycles);
      end
      uc_master <= 1'b1;
      hold_pins(hold_cycles);
      end_xfer();
      push_result(got, expect_read(1'b0, a), $sformatf("uC read %h", a));
   endtask

   // ----------------------------------------
   // LE read tasks
   // ----------------------------------------
   task automatic open_le_read();
      int cycles;
      cycles = 0;
      @(posedge clk);
      le_req <= 1'b1;
      do begin
         @(posedge clk);
         cycles++;
         @(negedge clk);
      end while (!le_gnt && cycles < 16);
      if (!le_gnt) begin
         report_failure("no LE grant within 16 cycles of the request");
      end else begin
         assert (cycles == 1)
            else report_mismatch($sformatf("grant %0d cycles after request, expected 1", cycles));
      end
      @(posedge clk);
      le_req    <= 1'b0;
      le_open_m = 1'b1;
   endtask

   task automatic fetch_le_word(input logic [9:0] a);
      @(posedge clk);
      le_addr <= a;
      // read latency is fixed at 2 cycles
      repeat (2) @(posedge clk);
      @(negedge clk);
      push_result(le_data, expect_read(1'b1, {6'd0, a}), $sformatf("LE read %h", a));
   endtask

   task automatic close_le_read();
      @(posedge clk);
      le_done <= 1'b1;
      @(posedge clk);
      le_done   <= 1'b0;
      le_open_m = 1'b0;
      if (pending_m) swap_banks();
      // room for a deferred swap
      hold_pins(4);
   endtask

   task automatic le_read(input logic [9:0] base, input int n);
      int i;
      open_le_read();
      for (i = 0; i < n; i++) fetch_le_word(base + 10'(i));
      close_le_read();
   endtask

   // ----------------------------------------
   // test sequence
   // ----------------------------------------
   initial begin
      int i;
      uc_rst_n    = 1'b0;
      uc_cs       = 1'b0;
      uc_valid    = 1'b0;
      uc_master   = 1'b1;
      uc_data_in  = '0;
      le_req      = 1'b0;
      le_addr     = '0;
      le_done     = 1'b0;
      sel_m       = 1'b0;
      dirty_m     = 1'b0;
      pending_m   = 1'b0;
      le_open_m   = 1'b0;
      checks      = 0;
      errors      = 0;
      test_checks = 0;
      test_errors = 0;
      repeat (4) @(posedge clk);
      uc_rst_n <= 1'b1;
      hold_pins(4);

      uc_read(16'h0402);
      report_test("1 id word read");

      uc_write_burst(16'h8040, 4);
      for (i = 0; i < 4; i++) uc_read(16'h0040 + 16'(i));
      report_test("2 burst write, uC read");

      // interval mark with no LE read open swaps at once
      uc_write_burst(16'h8401, 1);
      le_read(10'h040, 4);
      report_test("3 bank swap, LE read");

      // reserved bits and bad fpga offsets
      uc_read(16'h1040);
      uc_read(16'h0403);
      uc_write_burst(16'h8050, 1);
      uc_write_burst(16'h9050, 1);
      uc_write_burst(16'h8850, 1);
      uc_write_burst(16'h8405, 1);
      uc_read(16'h0050);
      uc_write_burst(16'h8401, 1);
      le_read(10'h050, 1);
      report_test("4 invalid addresses");

      uc_abort(16'h8041, 2);
      uc_read(16'h0041);
      report_test("5 early cs drop");

      // mark arrives while the LE read is still open
      uc_write_burst(16'h8040, 4);
      open_le_read();
      fetch_le_word(10'h050);
      uc_write_burst(16'h8401, 1);
      fetch_le_word(10'h050);
      close_le_read();
      le_read(10'h040, 4);
      report_test("6 swap held by LE read");

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

   // watchdog sized from the transaction count
   initial begin
      #(n_xfers * xfer_cycles * clk_period);
      $display("watchdog expired, the test sequence did not finish in time");
      $display("test failed");
      $finish;
   end

endmodule

/* ucstats_top.f */
ucstats_pkg.sv
uc_input_sync.sv
uc_transfer_fsm.sv
stat_bank_ctrl.sv
stat_ram_dual.sv
ucstats_top.sv
ucstats_properties.sv
ucstats_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ucstats testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f ucstats_top.f --top-module ucstats_top_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vucstats_top_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "test failed" "$LOG"; then
   exit 1
fi
exit 0
